// File: design/stream_pkg.sv
package stream_pkg;

  // Character stream seen by every lane
  // One byte per char_in_vld strobe
  localparam int unsigned CHAR_W = 8;

  // Stream id carried with every packet
  // Selects the saved DFA state and the hit counter
  localparam int unsigned STREAM_ID_W = 6;

  // Number of independent streams tracked per lane
  // Sizes the state memory and the hit table
  localparam int unsigned NUM_STREAMS = 64;

  // Stream id width must cover every stream
  // Kept as a derived check value for users of the package
  localparam int unsigned STREAM_SPAN = 1 << STREAM_ID_W;

  // Sanity relation between the two stream constants
  localparam bit STREAM_ID_FITS = (NUM_STREAMS <= STREAM_SPAN);

endpackage : stream_pkg

// File: design/match_pkg.sv
package match_pkg;

  // DFA state word, wide enough for any pattern prefix count
  // Saved per stream and restored at packet start
  localparam int unsigned STATE_W = 11;

  // Regex lanes working on the shared character stream
  localparam int unsigned NUM_LANES = 2;

  // Lane index as seen on the host read port
  localparam int unsigned LANE_W = 1;

  // Per-lane, per-stream hit counter
  // Counters wrap silently
  localparam int unsigned HIT_W = 16;

  // Requesters on the hit table
  // One per lane plus the host read port
  localparam int unsigned NUM_REQ = NUM_LANES + 1;

  // Grant bit reserved for the host
  localparam int unsigned HOST_GNT = NUM_LANES;

endpackage : match_pkg

// File: design/literal_dfa.sv
`timescale 1ns/1ps

module literal_dfa
  import stream_pkg::*, match_pkg::*;
#(
  parameter logic [8*CHAR_W-1:0] PATTERN     = "GET /",
  parameter int unsigned         PATTERN_LEN = 5
)
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [CHAR_W-1:0]  char_in,
  input  logic               char_in_vld,
  input  logic [STATE_W-1:0] state_in,
  input  logic               state_in_vld,
  output logic [STATE_W-1:0] state_out,
  output logic               accept_out
);

  // Pattern slots in the packed string
  localparam int unsigned MAX_LEN = $bits(PATTERN) / CHAR_W;
  localparam int unsigned IDX_W   = $clog2(MAX_LEN);
  // String literal is right justified, so move the first byte to the top
  localparam logic [8*CHAR_W-1:0] PAT_ALIGNED = PATTERN << ((MAX_LEN - PATTERN_LEN) * CHAR_W);

  logic [CHAR_W-1:0]  pat_byte [MAX_LEN];
  logic [CHAR_W-1:0]  expect_byte;
  logic [STATE_W-1:0] state_nxt;
  logic               accept_nxt;

  // Byte i of the pattern, counted from the start of the string
  for (genvar i = 0; i < MAX_LEN; i++)
  begin : g_pat_byte
    assign pat_byte[i] = PAT_ALIGNED[(MAX_LEN-1-i)*CHAR_W +: CHAR_W];
  end

  // State is the matched prefix length, so it also points at the next byte
  assign expect_byte = pat_byte[state_out[IDX_W-1:0]];

  always_comb
  begin
    state_nxt  = state_out;
    accept_nxt = 1'b0;
    if (char_in_vld)
    begin
      if (char_in == expect_byte)
      begin
        // Full pattern seen, pulse accept and start over
        if (state_out == STATE_W'(PATTERN_LEN - 1))
        begin
          state_nxt  = '0;
          accept_nxt = 1'b1;
        end
        else
          state_nxt = state_out + 1'b1;
      end
      // Mismatch may still open a new match
      else if (char_in == pat_byte[0])
        state_nxt = STATE_W'(1);
      else
        state_nxt = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out  <= '0;
      accept_out <= 1'b0;
    end
    // Restored state overrides any character in flight
    else if (state_in_vld)
    begin
      state_out  <= state_in;
      accept_out <= 1'b0;
    end
    else
    begin
      state_out  <= state_nxt;
      accept_out <= accept_nxt;
    end
  end

endmodule : literal_dfa

// File: design/regex_lane.sv
`timescale 1ns/1ps

module regex_lane
  import stream_pkg::*, match_pkg::*;
#(
  parameter logic [8*CHAR_W-1:0] PATTERN     = "GET /",
  parameter int unsigned         PATTERN_LEN = 5
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   eop,
  input  logic                   load_state,
  input  logic                   enable,
  input  logic                   char_in_vld,
  input  logic                   new_stream_id,
  input  logic [CHAR_W-1:0]      char_in,
  input  logic [STREAM_ID_W-1:0] stream_id,
  input  logic                   hit_gnt,
  output logic                   hit_req,
  output logic [STREAM_ID_W-1:0] hit_stream
);

  // Saved DFA state, one word per stream
  logic [STATE_W-1:0] state_mem [NUM_STREAMS];

  // Restore stage
  logic [STATE_W-1:0] state_in;
  logic               state_in_vld;

  // DFA input registers
  logic [CHAR_W-1:0]  char_in_r;
  logic               char_in_vld_r;
  logic [STATE_W-1:0] state_in_r;
  logic               state_in_vld_r;

  // DFA outputs and their registers
  logic [STATE_W-1:0] state_out;
  logic               accept_out;
  logic [STATE_W-1:0] state_out_r;
  logic               accept_out_r;

  // Set once any match is seen in the current packet
  logic match_flag;
  logic save_en;

  // Finalize only for lanes enabled on this packet
  assign save_en = eop & enable;

  // State memory: restore at packet start, save at enabled eop
  always_ff @(posedge clk)
  begin
    if (load_state)
      state_in <= new_stream_id ? '0 : state_mem[stream_id];
    if (save_en)
      state_mem[stream_id] <= state_out_r;
  end

  // Payload registers around the DFA
  always_ff @(posedge clk)
  begin
    char_in_r   <= char_in;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  // Control registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld   <= 1'b0;
      char_in_vld_r  <= 1'b0;
      state_in_vld_r <= 1'b0;
      accept_out_r   <= 1'b0;
      match_flag     <= 1'b0;
    end
    else
    begin
      state_in_vld   <= load_state;
      char_in_vld_r  <= char_in_vld;
      state_in_vld_r <= state_in_vld;
      accept_out_r   <= accept_out;
      // Flag lives for one packet only
      if (load_state || eop)
        match_flag <= 1'b0;
      else if (accept_out_r)
        match_flag <= 1'b1;
    end
  end

  // Hit request held until the table takes it
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      hit_req <= 1'b0;
    else if (save_en && match_flag)
      hit_req <= 1'b1;
    else if (hit_gnt)
      hit_req <= 1'b0;
  end

  // Stream of the pending hit, kept stable while hit_req is high
  always_ff @(posedge clk)
  begin
    if (save_en && match_flag)
      hit_stream <= stream_id;
  end

  literal_dfa #(
    .PATTERN     (PATTERN),
    .PATTERN_LEN (PATTERN_LEN)
  ) u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_in_vld  (char_in_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept_out   (accept_out)
  );

endmodule : regex_lane

// File: design/hit_arbiter.sv
`timescale 1ns/1ps

module hit_arbiter
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] lane_req,
  input  logic       host_req,
  output logic [2:0] gnt
);

  localparam int unsigned N = 3;

  // Requests ordered lane 0, lane 1, host
  logic [N-1:0] req;
  // Requester that gets first look this cycle
  logic [1:0]   prio;
  logic [1:0]   gnt_idx;

  assign req = {host_req, lane_req};

  // Search from prio upward, wrapping after the host
  always_comb
  begin
    int unsigned idx;
    gnt     = '0;
    gnt_idx = prio;
    for (int i = 0; i < N; i++)
    begin
      idx = prio + i;
      if (idx >= N)
        idx = idx - N;
      if (req[idx] && (gnt == '0))
      begin
        gnt[idx] = 1'b1;
        gnt_idx  = 2'(idx);
      end
    end
  end

  // Rotate past the winner so everyone waits at most two grants
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      prio <= '0;
    else if (gnt != '0)
      prio <= (gnt_idx == 2'(N - 1)) ? 2'd0 : gnt_idx + 2'd1;
  end

endmodule : hit_arbiter

// File: design/hit_table.sv
`timescale 1ns/1ps

module hit_table
  import stream_pkg::*, match_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [NUM_LANES:0]     gnt,
  input  logic [STREAM_ID_W-1:0] lane_stream0,
  input  logic [STREAM_ID_W-1:0] lane_stream1,
  input  logic [LANE_W-1:0]      rd_lane,
  input  logic [STREAM_ID_W-1:0] rd_stream,
  output logic [HIT_W-1:0]       rd_data,
  output logic                   rd_valid
);

  // Hit counters, row per lane, column per stream
  logic [HIT_W-1:0] cnt [NUM_LANES][NUM_STREAMS];

  // Lane grants bump their own counter
  // At most one grant is high, so one increment per cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
        for (int s = 0; s < NUM_STREAMS; s++)
        begin
          cnt[l][s] <= '0;
        end
      end
    end
    else
    begin
      if (gnt[0])
        cnt[0][lane_stream0] <= cnt[0][lane_stream0] + 1'b1;
      if (gnt[1])
        cnt[1][lane_stream1] <= cnt[1][lane_stream1] + 1'b1;
    end
  end

  // Host read data, valid one cycle after the host grant
  always_ff @(posedge clk)
  begin
    if (gnt[HOST_GNT])
      rd_data <= cnt[rd_lane][rd_stream];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= gnt[HOST_GNT];
  end

endmodule : hit_table

// File: design/inspect_top.sv
`timescale 1ns/1ps

module inspect_top
  import stream_pkg::*, match_pkg::*;
#(
  parameter logic [8*CHAR_W-1:0] LANE0_PATTERN = "GET /",
  parameter int unsigned         LANE0_LEN     = 5,
  parameter logic [8*CHAR_W-1:0] LANE1_PATTERN = "HTTP/1.",
  parameter int unsigned         LANE1_LEN     = 7
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   eop,
  input  logic                   load_state,
  input  logic                   char_in_vld,
  input  logic                   new_stream_id,
  input  logic                   rd_en,
  input  logic [NUM_LANES-1:0]   enable,
  input  logic [CHAR_W-1:0]      char_in,
  input  logic [STREAM_ID_W-1:0] stream_id,
  input  logic [LANE_W-1:0]      rd_lane,
  input  logic [STREAM_ID_W-1:0] rd_stream,
  output logic [HIT_W-1:0]       rd_data,
  output logic                   rd_valid
);

  logic [NUM_LANES-1:0]   hit_req;
  logic [STREAM_ID_W-1:0] hit_stream0;
  logic [STREAM_ID_W-1:0] hit_stream1;
  logic [NUM_LANES:0]     gnt;
  // Host read waiting for its slot on the table
  logic                   host_pend;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      host_pend <= 1'b0;
    else if (rd_en)
      host_pend <= 1'b1;
    else if (gnt[HOST_GNT])
      host_pend <= 1'b0;
  end

  regex_lane #(
    .PATTERN     (LANE0_PATTERN),
    .PATTERN_LEN (LANE0_LEN)
  ) u_lane0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .eop           (eop),
    .load_state    (load_state),
    .enable        (enable[0]),
    .char_in_vld   (char_in_vld),
    .new_stream_id (new_stream_id),
    .char_in       (char_in),
    .stream_id     (stream_id),
    .hit_gnt       (gnt[0]),
    .hit_req       (hit_req[0]),
    .hit_stream    (hit_stream0)
  );

  regex_lane #(
    .PATTERN     (LANE1_PATTERN),
    .PATTERN_LEN (LANE1_LEN)
  ) u_lane1 (
    .clk           (clk),
    .rst_n         (rst_n),
    .eop           (eop),
    .load_state    (load_state),
    .enable        (enable[1]),
    .char_in_vld   (char_in_vld),
    .new_stream_id (new_stream_id),
    .char_in       (char_in),
    .stream_id     (stream_id),
    .hit_gnt       (gnt[1]),
    .hit_req       (hit_req[1]),
    .hit_stream    (hit_stream1)
  );

  hit_arbiter u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_req (hit_req),
    .host_req (host_pend),
    .gnt      (gnt)
  );

  hit_table u_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .gnt          (gnt),
    .lane_stream0 (hit_stream0),
    .lane_stream1 (hit_stream1),
    .rd_lane      (rd_lane),
    .rd_stream    (rd_stream),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid)
  );

endmodule : inspect_top

// File: test/inspect_tb.sv
`timescale 1ns/1ps

module inspect_tb
  import stream_pkg::*, match_pkg::*;
();

  // Stimulus and expected counts, path from the project root
  localparam string       PATTERN_FILE = "test/inspect_patterns.txt";
  // Idle cycles between load_state and the first character strobe
  localparam int unsigned LOAD_GAP     = 1;
  // Idle cycles between the last character and eop
  localparam int unsigned EOP_GAP      = 4;
  // Minimum cycles from one eop to the next
  localparam int unsigned EOP_SPACING  = 10;
  localparam int unsigned RD_TIMEOUT   = 20;
  localparam int unsigned MAX_IDLE     = 3;

  logic                   clk;
  logic                   rst_n         = 1'b0;
  logic                   eop           = 1'b0;
  logic                   load_state    = 1'b0;
  logic                   char_in_vld   = 1'b0;
  logic                   new_stream_id = 1'b0;
  logic                   rd_en         = 1'b0;
  logic [NUM_LANES-1:0]   enable        = '0;
  logic [CHAR_W-1:0]      char_in       = '0;
  logic [STREAM_ID_W-1:0] stream_id     = '0;
  logic [LANE_W-1:0]      rd_lane       = '0;
  logic [STREAM_ID_W-1:0] rd_stream     = '0;
  logic [HIT_W-1:0]       rd_data;
  logic                   rd_valid;

  integer      seed;
  // Free running cycle count, used for eop spacing
  int unsigned cycle    = 0;
  int unsigned last_eop = 0;

  inspect_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .eop           (eop),
    .load_state    (load_state),
    .char_in_vld   (char_in_vld),
    .new_stream_id (new_stream_id),
    .rd_en         (rd_en),
    .enable        (enable),
    .char_in       (char_in),
    .stream_id     (stream_id),
    .rd_lane       (rd_lane),
    .rd_stream     (rd_stream),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  task automatic finish_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "inspect_tb stopped on the first error");
  endtask

  // Guards against short or broken lines in the pattern file
  task automatic expect_fields(input int got, input int want, input byte cmd);
    if (got != want)
    begin
      $display("Pattern file: command %c has %0d fields, needs %0d", cmd, got, want);
      finish_with_failure();
    end
  endtask

  // Packet start: stream id, enables and restore pulse go out together
  task automatic load_packet(input logic [STREAM_ID_W-1:0] stream,
                             input logic                   new_flag,
                             input logic [NUM_LANES-1:0]   lane_en);
    @(posedge clk);
    stream_id     <= stream;
    new_stream_id <= new_flag;
    enable        <= lane_en;
    load_state    <= 1'b1;
    @(posedge clk);
    load_state <= 1'b0;
    // Restored state still has to pass the lane input registers
    repeat (LOAD_GAP) @(posedge clk);
  endtask

  // One byte strobe followed by 0 to 3 random idle cycles
  task automatic send_char(input logic [CHAR_W-1:0] ch);
    int unsigned idle;
    idle = {$random(seed)} % (MAX_IDLE + 1);
    @(posedge clk);
    char_in     <= ch;
    char_in_vld <= 1'b1;
    @(posedge clk);
    char_in_vld <= 1'b0;
    repeat (idle) @(posedge clk);
  endtask

  task automatic end_packet();
    // Let the last accept reach the packet flag
    repeat (EOP_GAP) @(posedge clk);
    // Bounded by EOP_SPACING cycles
    while (cycle - last_eop < EOP_SPACING)
      @(posedge clk);
    eop      <= 1'b1;
    last_eop = cycle;
    @(posedge clk);
    eop <= 1'b0;
  endtask

  // Host read of one counter, compared with the count from the file
  task automatic check_counter(input logic [LANE_W-1:0]      lane,
                               input logic [STREAM_ID_W-1:0] stream,
                               input logic [HIT_W-1:0]       expected);
    int unsigned waited;
    // Entered just after a rising edge, so a read can follow eop with no gap
    rd_en     <= 1'b1;
    rd_lane   <= lane;
    rd_stream <= stream;
    @(posedge clk);
    rd_en <= 1'b0;
    // Poll on the falling edge, away from DUT updates
    waited = 0;
    @(negedge clk);
    while (!rd_valid && waited < RD_TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    if (!rd_valid)
    begin
      $display("Host read of lane %0d stream %0d got no rd_valid within %0d cycles",
               lane, stream, RD_TIMEOUT);
      finish_with_failure();
    end
    assert (rd_data === expected)
    else
    begin
      $display("** Error at %0t: rd_data expected %h, actual %h (lane %0d stream %0d)",
               $time, expected, rd_data, lane, stream);
      finish_with_failure();
    end
    // Back on a rising edge for the next command
    @(posedge clk);
  endtask

  initial
  begin
    int                     fd;
    int                     code;
    byte                    cmd;
    string                  skipped;
    logic [STREAM_ID_W-1:0] stream;
    logic [LANE_W-1:0]      lane;
    logic                   new_flag;
    logic                   en0;
    logic                   en1;
    logic [CHAR_W-1:0]      ch;
    logic [HIT_W-1:0]       expected;
    seed = 90;
    fd   = $fopen(PATTERN_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open pattern file %s", PATTERN_FILE);
      finish_with_failure();
    end
    // Reset for 10 cycles
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    // One command letter, then its fields
    code = $fscanf(fd, " %c", cmd);
    while (code == 1)
    begin
      case (cmd)
        "#":
          code = $fgets(skipped, fd);
        "S":
        begin
          code = $fscanf(fd, " %h %h %h %h", stream, new_flag, en0, en1);
          expect_fields(code, 4, cmd);
          load_packet(stream, new_flag, {en1, en0});
        end
        "C":
        begin
          code = $fscanf(fd, " %h", ch);
          expect_fields(code, 1, cmd);
          send_char(ch);
        end
        "E":
          end_packet();
        "R":
        begin
          code = $fscanf(fd, " %h %h %h", lane, stream, expected);
          expect_fields(code, 3, cmd);
          check_counter(lane, stream, expected);
        end
        default:
        begin
          $display("Pattern file holds an unknown command %c", cmd);
          finish_with_failure();
        end
      endcase
      code = $fscanf(fd, " %c", cmd);
    end
    $fclose(fd);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : inspect_tb

// File: test/inspect_patterns.txt
# S stream new en0 en1 = packet start | C byte = one character | E = end of packet
# R lane stream count = host read and its expected counter, every number in hex
# Single packet match on lane 0, lane 1 stays zero
S 01 1 1 1 C 61 C 47 C 45 C 54 C 20 C 2F C 62 E
R 0 01 0001 R 1 01 0000
# Lane 1 pattern split across two packets of one stream
S 02 1 1 1 C 78 C 48 C 54 C 54 E
S 02 0 1 1 C 50 C 2F C 31 C 2E E
R 1 02 0001
# Same split, second packet flagged as a new stream
S 03 1 1 1 C 48 C 54 C 54 E
S 03 1 1 1 C 50 C 2F C 31 C 2E E
R 1 03 0000
# Lane 1 disabled on a matching middle packet
S 04 1 1 1 C 48 C 54 C 54 E
S 04 0 1 0 C 48 C 54 C 54 C 50 C 2F C 31 C 2E E
R 1 04 0000
# Resumes from the state saved before the disabled packet
S 04 0 1 1 C 50 C 2F C 31 C 2E E
R 1 04 0001
# Two lane 0 matches in one packet count once
S 05 1 1 1 C 47 C 45 C 54 C 20 C 2F C 47 C 45 C 54 C 20 C 2F E
R 0 05 0001
# Both lanes hit at one eop, host read right behind
S 06 1 1 1 C 47 C 45 C 54 C 20 C 2F C 48 C 54 C 54 C 50 C 2F C 31 C 2E E
R 0 01 0001 R 0 06 0001 R 1 06 0001
S 06 0 1 1 C 47 C 45 C 54 C 20 C 2F C 48 C 54 C 54 C 50 C 2F C 31 C 2E E
R 0 05 0001 R 1 06 0002 R 0 06 0002
# Earlier counters are untouched
R 0 01 0001 R 1 02 0001 R 1 03 0000 R 1 04 0001

// File: vlog.f
design/stream_pkg.sv
design/match_pkg.sv
design/literal_dfa.sv
design/regex_lane.sv
design/hit_arbiter.sv
design/hit_table.sv
design/inspect_top.sv
test/inspect_tb.sv

// File: Bender.yml
package:
  name: packet_inspect

sources:
  # Packages first, then the modules bottom up
  - design/stream_pkg.sv
  - design/match_pkg.sv
  - design/literal_dfa.sv
  - design/regex_lane.sv
  - design/hit_arbiter.sv
  - design/hit_table.sv
  - design/inspect_top.sv

  - target: test
    files:
      - test/inspect_tb.sv
